// ==== design/dz_pkg.sv ====
package dz_pkg;

    // matrix geometry
    localparam int ROWS  = 8;
    localparam int COLS  = 8;
    localparam int ROW_W = 3;

    // level range, 0 is the smallest blob and MAX_LEVEL is fully lit
    localparam int LEVEL_W   = 4;
    localparam int MAX_LEVEL = 9;

    // temperature samples
    localparam int TEMP_W     = 8;
    localparam int LEVEL_STEP = 16;  // sample span per level

    // alarm hysteresis band
    localparam int ALARM_HI = 144;   // set at or above
    localparam int ALARM_LO = 128;   // clear below

    // per-frame display mode
    typedef enum logic [1:0] {
        DISP_OFF    = 2'd0,
        DISP_NORMAL = 2'd1,
        DISP_ALARM  = 2'd2
    } disp_mode_e;

    // encoder result as seen by the display driver
    typedef struct packed {
        logic [LEVEL_W-1:0] level;
        logic               alarm;
    } temp_status_t;

endpackage

// ==== design/dz_show.sv ====
module dz_show (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       st,
    input  dz_pkg::temp_status_t       status,
    output logic [dz_pkg::LEVEL_W-1:0] rom_level,
    output logic [dz_pkg::ROW_W-1:0]   rom_row,
    input  logic [dz_pkg::COLS-1:0]    pattern,
    output logic [dz_pkg::ROWS-1:0]    row,
    output logic [dz_pkg::COLS-1:0]    colg,
    output logic [dz_pkg::COLS-1:0]    colr
);

    logic [dz_pkg::ROW_W-1:0]   row_idx;     // row shown at the next edge
    logic [dz_pkg::LEVEL_W-1:0] level_q;
    dz_pkg::disp_mode_e         mode_q;
    dz_pkg::disp_mode_e         st_mode;
    dz_pkg::disp_mode_e         cur_mode;
    logic                       frame_start;
    logic [dz_pkg::COLS-1:0]    green;

    assign frame_start = (row_idx == '0);

    // mode taken from the live inputs, used only when a frame starts
    always_comb
    begin
        if (!st)
        begin
            st_mode = dz_pkg::DISP_OFF;
        end
        else if (status.alarm)
        begin
            st_mode = dz_pkg::DISP_ALARM;
        end
        else
        begin
            st_mode = dz_pkg::DISP_NORMAL;
        end
    end

    // row 0 already uses the values being latched
    assign cur_mode  = frame_start ? st_mode : mode_q;
    assign rom_level = frame_start ? status.level : level_q;
    assign rom_row   = row_idx;

    assign green = (cur_mode == dz_pkg::DISP_OFF) ? '0 : pattern;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row_idx <= '0;
            level_q <= '0;
            mode_q  <= dz_pkg::DISP_OFF;
            row     <= '1;  // nothing lit
            colg    <= '0;
            colr    <= '0;
        end
        else
        begin
            row_idx <= row_idx + dz_pkg::ROW_W'(1);  // wraps after 7
            if (frame_start)
            begin
                level_q <= status.level;
                mode_q  <= st_mode;
            end
            row  <= ~(dz_pkg::ROWS'(1) << row_idx);
            colg <= green;
            colr <= (cur_mode == dz_pkg::DISP_ALARM) ? green : '0;  // amber
        end
    end

endmodule

// ==== design/dz_top.sv ====
module dz_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      st,
    input  logic [dz_pkg::TEMP_W-1:0] sample,
    input  logic                      sample_valid,
    output logic [dz_pkg::ROWS-1:0]   row,
    output logic [dz_pkg::COLS-1:0]   colg,
    output logic [dz_pkg::COLS-1:0]   colr
);

    dz_pkg::temp_status_t       status;
    logic [dz_pkg::LEVEL_W-1:0] rom_level;
    logic [dz_pkg::ROW_W-1:0]   rom_row;
    logic [dz_pkg::COLS-1:0]    pattern;

    temp_level_enc i_enc (
        .clk          (clk),
        .rst          (rst),
        .sample       (sample),
        .sample_valid (sample_valid),
        .status       (status)
    );

    dz_show i_show (
        .clk       (clk),
        .rst       (rst),
        .st        (st),
        .status    (status),
        .rom_level (rom_level),
        .rom_row   (rom_row),
        .pattern   (pattern),
        .row       (row),
        .colg      (colg),
        .colr      (colr)
    );

    glyph_rom i_rom (
        .level   (rom_level),
        .row_idx (rom_row),
        .pattern (pattern)
    );

endmodule

// ==== design/glyph_rom.sv ====
module glyph_rom (
    input  logic [dz_pkg::LEVEL_W-1:0] level,
    input  logic [dz_pkg::ROW_W-1:0]   row_idx,
    output logic [dz_pkg::COLS-1:0]    pattern
);

    // blobs stay centered and grow outward with the level
    always_comb
    begin
        pattern = '0;  // blank rows and out-of-range levels
        case (level)
            4'd0:
            begin
                case (row_idx)
                    3'd3, 3'd4: pattern = 8'b0001_1000;
                    default:    pattern = '0;
                endcase
            end
            4'd1:
            begin
                case (row_idx)
                    3'd2, 3'd5: pattern = 8'b0001_1000;
                    3'd3, 3'd4: pattern = 8'b0011_1100;
                    default:    pattern = '0;
                endcase
            end
            4'd2:
            begin
                case (row_idx)
                    3'd2, 3'd3, 3'd4, 3'd5: pattern = 8'b0011_1100;
                    default:                pattern = '0;
                endcase
            end
            4'd3:
            begin
                case (row_idx)
                    3'd2, 3'd5: pattern = 8'b0011_1100;
                    3'd3, 3'd4: pattern = 8'b0111_1110;
                    default:    pattern = '0;
                endcase
            end
            4'd4:
            begin
                case (row_idx)
                    3'd1, 3'd6:             pattern = 8'b0011_1100;
                    3'd2, 3'd3, 3'd4, 3'd5: pattern = 8'b0111_1110;
                    default:                pattern = '0;
                endcase
            end
            4'd5:
            begin
                case (row_idx)
                    3'd0, 3'd7: pattern = '0;
                    default:    pattern = 8'b0111_1110;  // tall block
                endcase
            end
            4'd6:
            begin
                case (row_idx)
                    3'd0, 3'd7: pattern = 8'b0011_1100;
                    3'd1, 3'd6: pattern = 8'b0111_1110;
                    default:    pattern = 8'b1111_1111;
                endcase
            end
            4'd7:
            begin
                case (row_idx)
                    3'd0, 3'd7: pattern = 8'b0011_1100;
                    default:    pattern = 8'b1111_1111;
                endcase
            end
            4'd8:
            begin
                case (row_idx)
                    3'd0, 3'd7: pattern = 8'b0111_1110;  // only corners dark
                    default:    pattern = 8'b1111_1111;
                endcase
            end
            4'd9:
            begin
                pattern = 8'b1111_1111;
            end
            default:
            begin
                pattern = '0;
            end
        endcase
    end

endmodule

// ==== design/temp_level_enc.sv ====
module temp_level_enc (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [dz_pkg::TEMP_W-1:0] sample,
    input  logic                      sample_valid,
    output dz_pkg::temp_status_t      status
);

    logic [dz_pkg::TEMP_W-1:0]  quot;
    logic [dz_pkg::LEVEL_W-1:0] level_next;
    logic                       alarm_next;

    // coarse level from the sample
    assign quot = sample / dz_pkg::TEMP_W'(dz_pkg::LEVEL_STEP);

    always_comb
    begin
        if (quot > dz_pkg::TEMP_W'(dz_pkg::MAX_LEVEL))
        begin
            level_next = dz_pkg::LEVEL_W'(dz_pkg::MAX_LEVEL);  // clamp
        end
        else
        begin
            level_next = quot[dz_pkg::LEVEL_W-1:0];
        end
    end

    // two thresholds, between them the flag holds
    always_comb
    begin
        if (sample >= dz_pkg::TEMP_W'(dz_pkg::ALARM_HI))
        begin
            alarm_next = 1'b1;
        end
        else if (sample < dz_pkg::TEMP_W'(dz_pkg::ALARM_LO))
        begin
            alarm_next = 1'b0;
        end
        else
        begin
            alarm_next = status.alarm;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            status.level <= '0;
            status.alarm <= 1'b0;
        end
        else if (sample_valid)
        begin
            status.level <= level_next;
            status.alarm <= alarm_next;
        end
    end

endmodule

// ==== flist.f ====
design/dz_pkg.sv
design/temp_level_enc.sv
design/glyph_rom.sv
design/dz_show.sv
design/dz_top.sv
sim/dz_assert.sv
sim/dz_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the LED matrix testbench with Verilator and runs it
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module dz_tb \
    -f flist.f \
    -o dz_sim

status=0
./obj_dir/dz_sim 2>&1 | tee "$LOG" || status=$?

if grep -q "Simulation finished: FAIL" "$LOG" || [ "$status" -ne 0 ]; then
    echo "simulation failed, see $LOG"
    exit 1
fi
echo "simulation passed"

// ==== sim/dz_assert.sv ====
module dz_assert (
    input logic                    clk,
    input logic                    rst,
    input logic [dz_pkg::ROWS-1:0] row,
    input logic [dz_pkg::COLS-1:0] colg,
    input logic [dz_pkg::COLS-1:0] colr,
    input dz_pkg::disp_mode_e      mode_q
);
    timeunit 1ns;
    timeprecision 100ps;

    // one row lit once the scan runs
    a_one_row: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> $onehot(~row))
        else $error("row %h does not have exactly one low bit", row);

    // active-low bit rotates up one position, 7 wraps to 0
    a_row_step: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |=> row == {$past(row[dz_pkg::ROWS-2:0]), $past(row[dz_pkg::ROWS-1])})
        else $error("row %h did not advance by one position", row);

    a_red_copy: assert property (@(posedge clk) disable iff (rst)
        colr == '0 || colr == colg)
        else $error("colr %h is neither blank nor equal to colg %h", colr, colg);

    a_off_blank: assert property (@(posedge clk) disable iff (rst)
        mode_q == dz_pkg::DISP_OFF |-> (colg == '0 && colr == '0))
        else $error("columns lit while the display is off");

endmodule

bind dz_show dz_assert i_assert (
    .clk    (clk),
    .rst    (rst),
    .row    (row),
    .colg   (colg),
    .colr   (colr),
    .mode_q (mode_q)
);

// ==== sim/dz_golden.txt ====
// glyph lines: eight green column bytes, rows 0 to 7, for levels 0 to 9
// records: sample st level alarm; a record with st = ff closes the list
00 00 00 18 18 00 00 00
00 00 18 3c 3c 18 00 00
00 00 3c 3c 3c 3c 00 00
00 00 3c 7e 7e 3c 00 00
00 3c 7e 7e 7e 7e 3c 00
00 7e 7e 7e 7e 7e 7e 00
3c 7e ff ff ff ff 7e 3c
3c ff ff ff ff ff ff 3c
7e ff ff ff ff ff ff 7e
ff ff ff ff ff ff ff ff
// rising ramp, alarm sets at 144
00 1 0 0
10 1 1 0
20 1 2 0
30 1 3 0
40 1 4 0
50 1 5 0
60 1 6 0
70 1 7 0
80 1 8 0
8f 1 8 0
90 1 9 1
a0 1 9 1
c8 1 9 1
ff 1 9 1
// falling, held at 130 and cleared at 127
90 1 9 1
82 1 8 1
80 1 8 1
7f 1 7 0
8a 1 8 0
// enable off and back on
3c 1 3 0
3c 0 3 0
65 0 6 0
65 1 6 0
9a 0 9 1
9a 1 9 1
85 1 8 1
// mixed values
07 1 0 0
1f 1 1 0
4e 1 4 0
5a 1 5 0
9f 1 9 1
8f 0 8 1
8f 1 8 1
7f 1 7 0
// end of records
00 ff 00 00

// ==== sim/dz_tb.sv ====
module dz_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD  = 40;
    localparam int GLYPH_WORDS = (dz_pkg::MAX_LEVEL + 1) * dz_pkg::ROWS;
    localparam int REC_WORDS   = 4;  // sample, st, level, alarm
    localparam int MAX_RECS    = 64;
    localparam int MEM_WORDS   = GLYPH_WORDS + REC_WORDS * MAX_RECS;
    localparam int N_RAND      = 12;
    localparam logic [7:0] END_MARK = 8'hff;  // st column of the closing record

    logic                        clk;
    logic                        rst;
    logic                        st;
    logic [dz_pkg::TEMP_W-1:0]   sample;
    logic                        sample_valid;
    logic [dz_pkg::ROWS-1:0]     row;
    logic [dz_pkg::COLS-1:0]     colg;
    logic [dz_pkg::COLS-1:0]     colr;

    logic [7:0]  gold [0:MEM_WORDS-1];
    int          n_recs;
    int          err_count;
    int          check_count;
    logic        model_alarm;
    logic [31:0] rng;
    bit          loaded;
    longint      wd_limit;

    dz_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .st           (st),
        .sample       (sample),
        .sample_valid (sample_valid),
        .row          (row),
        .colg         (colg),
        .colr         (colr)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        wait (loaded);
        #(wd_limit);
        $display("timeout: the scanned frames did not all arrive within %0d ns", wd_limit);
        $display("Simulation finished: FAIL");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // sample span per level, clamped at the top glyph
    function automatic logic [dz_pkg::LEVEL_W-1:0] level_of(input logic [7:0] s);
        int q;
        q = int'(s) / dz_pkg::LEVEL_STEP;
        if (q > dz_pkg::MAX_LEVEL)
            q = dz_pkg::MAX_LEVEL;
        return dz_pkg::LEVEL_W'(q);
    endfunction

    function automatic logic alarm_after(input logic [7:0] s, input logic prev);
        if (int'(s) >= dz_pkg::ALARM_HI)
            return 1'b1;
        if (int'(s) < dz_pkg::ALARM_LO)
            return 1'b0;
        return prev;  // inside the band
    endfunction

    task automatic expect_eq(input string what, input logic [7:0] got, input logic [7:0] exp);
        check_count++;
        assert (got === exp)
        else
        begin
            $display("error %0t: %s is %h, expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic drive_sample(input logic [7:0] s, input logic en);
        @(posedge clk);
        #2;
        sample       = s;
        st           = en;
        sample_valid = 1'b1;
        @(posedge clk);
        #2;
        sample_valid = 1'b0;
    endtask

    task automatic wait_frame_start(output bit found);
        int n;
        found = 1'b0;
        @(negedge clk);  // still the row of the strobe edge
        for (n = 0; n < 2 * dz_pkg::ROWS && !found; n++)
        begin
            @(negedge clk);
            if (row == ~dz_pkg::ROWS'(1))
                found = 1'b1;
        end
    endtask

    task automatic check_frame(input logic [3:0] lvl, input logic en, input logic alm);
        int         r;
        logic [7:0] exp_g;
        logic [7:0] exp_r;
        for (r = 0; r < dz_pkg::ROWS; r++)
        begin
            if (r > 0)
                @(negedge clk);
            exp_g = en ? gold[int'(lvl) * dz_pkg::ROWS + r] : 8'h00;
            exp_r = (en && alm) ? exp_g : 8'h00;
            expect_eq($sformatf("row line at row %0d", r), row, ~(dz_pkg::ROWS'(1) << r));
            expect_eq($sformatf("colg at row %0d level %0d", r, lvl), colg, exp_g);
            expect_eq($sformatf("colr at row %0d level %0d", r, lvl), colr, exp_r);
        end
    endtask

    task automatic run_frame_test(input logic [7:0] s, input logic en, input logic [3:0] lvl,
                                  input logic alm, input string tag);
        bit found;
        drive_sample(s, en);
        wait_frame_start(found);
        if (!found)
        begin
            $display("no frame start was seen after the %s sample", tag);
            err_count++;
        end
        else
        begin
            repeat (dz_pkg::ROWS) @(negedge clk);  // one whole frame skipped
            check_frame(lvl, en, alm);
        end
    endtask

    initial
    begin
        int         i;
        int         k;
        int         base;
        logic [7:0] s;
        logic       en;
        logic [3:0] lvl;
        logic       alm;

        rst          = 1'b1;
        st           = 1'b0;
        sample       = '0;
        sample_valid = 1'b0;
        err_count    = 0;
        check_count  = 0;
        model_alarm  = 1'b0;
        rng          = 32'd96;
        loaded       = 1'b0;

        $readmemh("sim/dz_golden.txt", gold);
        n_recs = 0;
        while (n_recs < MAX_RECS && gold[GLYPH_WORDS + REC_WORDS * n_recs + 1] != END_MARK)
            n_recs++;
        if (n_recs == 0)
        begin
            $display("the golden file sim/dz_golden.txt holds no sample records");
            err_count++;
        end
        wd_limit = longint'(n_recs + N_RAND + 4) * 3 * dz_pkg::ROWS * CLK_PERIOD
                   + longint'(4000);
        loaded = 1'b1;

        repeat (3)
        begin
            @(negedge clk);
            expect_eq("row in reset", row, 8'hff);
            expect_eq("colg in reset", colg, 8'h00);
            expect_eq("colr in reset", colr, 8'h00);
        end
        @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        expect_eq("row after release", row, 8'hff);
        expect_eq("colg after release", colg, 8'h00);
        expect_eq("colr after release", colr, 8'h00);

        // two frames of plain scanning with st low
        for (k = 0; k < 2 * dz_pkg::ROWS; k++)
        begin
            @(negedge clk);
            expect_eq($sformatf("scan step %0d", k), row, ~(dz_pkg::ROWS'(1) << (k % 8)));
            expect_eq($sformatf("colg at scan step %0d", k), colg, 8'h00);
            expect_eq($sformatf("colr at scan step %0d", k), colr, 8'h00);
        end

        for (i = 0; i < n_recs; i++)
        begin
            base        = GLYPH_WORDS + REC_WORDS * i;
            s           = gold[base];
            en          = gold[base + 1][0];
            lvl         = level_of(s);
            alm         = alarm_after(s, model_alarm);
            model_alarm = alm;
            expect_eq($sformatf("golden level of record %0d", i), gold[base + 2], {4'h0, lvl});
            expect_eq($sformatf("golden alarm of record %0d", i), gold[base + 3], {7'h0, alm});
            run_frame_test(s, en, lvl, alm, $sformatf("golden record %0d", i));
        end

        for (i = 0; i < N_RAND; i++)
        begin
            rng         = xorshift32(rng);
            s           = rng[7:0];
            en          = rng[8] | rng[9];  // mostly enabled
            lvl         = level_of(s);
            alm         = alarm_after(s, model_alarm);
            model_alarm = alm;
            run_frame_test(s, en, lvl, alm, $sformatf("random %0d", i));
        end

        $display("checks: %0d errors: %0d", check_count, err_count);
        if (err_count == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule
